// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_nebula
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
+incdir+.
nebula_pkg.sv
wb_arbiter.sv
wb_decoder.sv
gpio_control.sv
la_control.sv
wb_sram.sv
nebula_top.sv
nebula_assert.sv
tb_nebula.sv

// File: gpio_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pad ownership control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "nebula_params.svh"

module gpio_control (
    input  logic                wb_clk_i,
    input  logic                reset_i,

    input  logic                stb_i,
    input  logic                we_i,
    input  nebula_pkg::wb_sel_t sel_i,
    input  nebula_pkg::wb_adr_t adr_i,
    input  nebula_pkg::wb_dat_t dat_i,
    output logic                ack_o,
    output nebula_pkg::wb_dat_t dat_o,

    // Pad vectors of each team, team 1 in the lowest slot
    input  nebula_pkg::pad_vec_t [`NUM_TEAMS-1:0] team_out_i,
    input  nebula_pkg::pad_vec_t [`NUM_TEAMS-1:0] team_oeb_i,
    output nebula_pkg::pad_vec_t pad_out_o,
    output nebula_pkg::pad_vec_t pad_oeb_o          // Active low enable
);

    localparam int NUM_WORDS = (`NUM_PADS + 7) / 8;   // Eight fields per word

    nebula_pkg::team_sel_t pin_sel [`NUM_PADS];
    logic [2:0]            word_idx;
    logic                  word_ok;
    logic                  wr_en;
    nebula_pkg::wb_dat_t   rd_word;

    assign word_idx = adr_i[4:2];
    assign word_ok  = (adr_i[15:5] == '0) && (word_idx < 3'(NUM_WORDS));
    assign wr_en    = stb_i & we_i & ~ack_o & word_ok;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            for (int p = 0; p < `NUM_PADS; p++)
                pin_sel[p] <= '0;
        end else if (wr_en) begin
            for (int p = 0; p < `NUM_PADS; p++) begin
                // Each byte lane holds two pin fields
                if (word_idx == 3'(p / 8) && sel_i[(p % 8) / 2])
                    pin_sel[p] <= dat_i[4 * (p % 8) +: 4];
            end
        end
    end

    always_comb begin
        rd_word = '0;
        for (int p = 0; p < `NUM_PADS; p++) begin
            if (word_ok && word_idx == 3'(p / 8))
                rd_word[4 * (p % 8) +: 4] = pin_sel[p];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i & ~ack_o;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (stb_i && !ack_o) dat_o <= rd_word;
    end

    always_comb begin
        for (int p = 0; p < `NUM_PADS; p++) begin
            pad_out_o[p] = 1'b0;
            pad_oeb_o[p] = 1'b1;        // Unowned pad stays an input
            for (int t = 1; t <= `NUM_TEAMS; t++) begin
                if (pin_sel[p] == nebula_pkg::team_sel_t'(t)) begin
                    pad_out_o[p] = team_out_i[t - 1][p];
                    pad_oeb_o[p] = team_oeb_i[t - 1][p];
                end
            end
        end
    end

endmodule

// File: la_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Logic analyzer bank control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "nebula_params.svh"

module la_control (
    input  logic                wb_clk_i,
    input  logic                reset_i,

    input  logic                stb_i,
    input  logic                we_i,
    input  nebula_pkg::wb_sel_t sel_i,
    input  nebula_pkg::wb_adr_t adr_i,
    input  nebula_pkg::wb_dat_t dat_i,
    output logic                ack_o,
    output nebula_pkg::wb_dat_t dat_o,

    input  nebula_pkg::la_vec_t [`NUM_TEAMS-1:0] team_la_i,
    output nebula_pkg::la_vec_t la_out_o
);

    localparam int BANKS = 4;
    localparam int LANES = 32;      // Lanes per bank

    nebula_pkg::team_sel_t bank_sel [BANKS];
    nebula_pkg::wb_dat_t   rd_word;
    logic                  wr_en;

    // Single register at offset 0, bank k in byte k
    assign wr_en = stb_i & we_i & ~ack_o & (adr_i[15:2] == '0);

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            for (int k = 0; k < BANKS; k++)
                bank_sel[k] <= '0;
        end else if (wr_en) begin
            for (int k = 0; k < BANKS; k++)
                if (sel_i[k]) bank_sel[k] <= dat_i[8 * k +: 4];
        end
    end

    always_comb begin
        rd_word = '0;
        for (int k = 0; k < BANKS; k++)
            rd_word[8 * k +: 4] = bank_sel[k];
        if (adr_i[15:2] != '0) rd_word = '0;
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i & ~ack_o;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (stb_i && !ack_o) dat_o <= rd_word;
    end

    always_comb begin
        la_out_o = '0;
        for (int k = 0; k < BANKS; k++) begin
            for (int t = 1; t <= `NUM_TEAMS; t++) begin
                if (bank_sel[k] == nebula_pkg::team_sel_t'(t))
                    la_out_o[LANES * k +: LANES] = team_la_i[t - 1][LANES * k +: LANES];
            end
        end
    end

endmodule

// File: nebula_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Nebula bus protocol checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module nebula_assert (
    input logic                 clk_i,
    input logic                 reset_i,
    input logic                 soc_cyc_i,
    input logic                 soc_ack_i,
    input logic                 team_cyc_i,
    input logic                 team_ack_i,
    input nebula_pkg::pad_vec_t pad_oeb_i
);
    timeunit 1ns;
    timeprecision 1ps;

    soc_ack_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        soc_ack_i |=> !soc_ack_i)
        else $error("SoC manager ack lasted more than one cycle");

    team_ack_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        team_ack_i |=> !team_ack_i)
        else $error("Team manager ack lasted more than one cycle");

    acks_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
        !(soc_ack_i && team_ack_i))
        else $error("Both manager acks high in the same cycle");

    // Ack only inside the manager's own bus cycle
    soc_ack_in_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
        soc_ack_i |-> soc_cyc_i)
        else $error("SoC manager acked with cyc low");

    team_ack_in_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
        team_ack_i |-> team_cyc_i)
        else $error("Team manager acked with cyc low");

    // Sync reset needs one edge before the enables settle
    oeb_in_reset: assert property (@(posedge clk_i) reset_i |=> &pad_oeb_i)
        else $error("Pad output enables not all high during reset");

endmodule

// File: nebula_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Nebula shared bus parameters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef NEBULA_PARAMS_SVH
`define NEBULA_PARAMS_SVH

// Team designs feeding pads and LA
`define NUM_TEAMS   2
`define NUM_PADS    38              // Breakout board pads

// SRAM depth in 32-bit words
`define SRAM_WORDS  256

// Region bases, 64 KiB each, decoded on bits 31..16
`define SRAM_BASE   32'h3000_0000
`define GPIO_BASE   32'h3001_0000
`define LA_BASE     32'h3002_0000

`endif

// File: nebula_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Nebula shared bus types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "nebula_params.svh"

package nebula_pkg;

    // Wishbone bus fields
    typedef logic [31:0] wb_adr_t;
    typedef logic [31:0] wb_dat_t;
    typedef logic [3:0]  wb_sel_t;     // Byte select

    // Team index, 0 or above NUM_TEAMS means default
    typedef logic [3:0] team_sel_t;

    typedef logic [`NUM_PADS-1:0] pad_vec_t;
    typedef logic [127:0]         la_vec_t;    // Four banks of 32 lanes

    // Bus ownership
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_M0,     // SoC manager owns the bus
        ARB_M1      // Team manager owns the bus
    } arb_state_t;

endpackage

// File: nebula_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Nebula shared bus top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "nebula_params.svh"

module nebula_top (
    input  logic                wb_clk_i,
    input  logic                reset_i,

    // Management SoC manager
    input  logic                wbs_cyc_i,
    input  logic                wbs_stb_i,
    input  logic                wbs_we_i,
    input  nebula_pkg::wb_sel_t wbs_sel_i,
    input  nebula_pkg::wb_adr_t wbs_adr_i,
    input  nebula_pkg::wb_dat_t wbs_dat_i,
    output logic                wbs_ack_o,
    output nebula_pkg::wb_dat_t wbs_dat_o,

    // Team design manager
    input  logic                team_cyc_i,
    input  logic                team_stb_i,
    input  logic                team_we_i,
    input  nebula_pkg::wb_sel_t team_sel_i,
    input  nebula_pkg::wb_adr_t team_adr_i,
    input  nebula_pkg::wb_dat_t team_dat_i,
    output logic                team_ack_o,
    output nebula_pkg::wb_dat_t team_dat_o,

    // Team pad and LA outputs, team 1 in the lowest slot
    input  nebula_pkg::pad_vec_t [`NUM_TEAMS-1:0] team_gpio_out_i,
    input  nebula_pkg::pad_vec_t [`NUM_TEAMS-1:0] team_gpio_oeb_i,
    input  nebula_pkg::la_vec_t  [`NUM_TEAMS-1:0] team_la_i,

    output nebula_pkg::pad_vec_t io_out_o,
    output nebula_pkg::pad_vec_t io_oeb_o,
    output nebula_pkg::la_vec_t  la_data_out_o
);

    // Shared bus after arbitration
    logic                m_cyc, m_stb, m_we, m_ack;
    nebula_pkg::wb_sel_t m_sel;
    nebula_pkg::wb_adr_t m_adr;
    nebula_pkg::wb_dat_t m_dat, m_rdat;

    logic                sram_stb, gpio_stb, la_stb;
    logic                sram_ack, gpio_ack, la_ack;
    nebula_pkg::wb_dat_t sram_dat, gpio_dat, la_dat;

    wb_arbiter u_arbiter (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .s0_cyc_i (wbs_cyc_i),
        .s0_stb_i (wbs_stb_i),
        .s0_we_i  (wbs_we_i),
        .s0_sel_i (wbs_sel_i),
        .s0_adr_i (wbs_adr_i),
        .s0_dat_i (wbs_dat_i),
        .s0_ack_o (wbs_ack_o),
        .s0_dat_o (wbs_dat_o),
        .s1_cyc_i (team_cyc_i),
        .s1_stb_i (team_stb_i),
        .s1_we_i  (team_we_i),
        .s1_sel_i (team_sel_i),
        .s1_adr_i (team_adr_i),
        .s1_dat_i (team_dat_i),
        .s1_ack_o (team_ack_o),
        .s1_dat_o (team_dat_o),
        .m_cyc_o  (m_cyc),
        .m_stb_o  (m_stb),
        .m_we_o   (m_we),
        .m_sel_o  (m_sel),
        .m_adr_o  (m_adr),
        .m_dat_o  (m_dat),
        .m_ack_i  (m_ack),
        .m_dat_i  (m_rdat)
    );

    wb_decoder u_decoder (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .m_cyc_i    (m_cyc),
        .m_stb_i    (m_stb),
        .m_adr_i    (m_adr),
        .m_ack_o    (m_ack),
        .m_dat_o    (m_rdat),
        .sram_stb_o (sram_stb),
        .gpio_stb_o (gpio_stb),
        .la_stb_o   (la_stb),
        .sram_ack_i (sram_ack),
        .sram_dat_i (sram_dat),
        .gpio_ack_i (gpio_ack),
        .gpio_dat_i (gpio_dat),
        .la_ack_i   (la_ack),
        .la_dat_i   (la_dat)
    );

    gpio_control u_gpio (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .stb_i      (gpio_stb),
        .we_i       (m_we),
        .sel_i      (m_sel),
        .adr_i      (m_adr),
        .dat_i      (m_dat),
        .ack_o      (gpio_ack),
        .dat_o      (gpio_dat),
        .team_out_i (team_gpio_out_i),
        .team_oeb_i (team_gpio_oeb_i),
        .pad_out_o  (io_out_o),
        .pad_oeb_o  (io_oeb_o)
    );

    la_control u_la (
        .wb_clk_i  (wb_clk_i),
        .reset_i   (reset_i),
        .stb_i     (la_stb),
        .we_i      (m_we),
        .sel_i     (m_sel),
        .adr_i     (m_adr),
        .dat_i     (m_dat),
        .ack_o     (la_ack),
        .dat_o     (la_dat),
        .team_la_i (team_la_i),
        .la_out_o  (la_data_out_o)
    );

    wb_sram u_sram (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .stb_i    (sram_stb),
        .we_i     (m_we),
        .sel_i    (m_sel),
        .adr_i    (m_adr),
        .dat_i    (m_dat),
        .ack_o    (sram_ack),
        .dat_o    (sram_dat)
    );

endmodule

// File: tb_nebula.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Nebula shared bus testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "nebula_params.svh"

module tb_nebula;
    timeunit 1ns;
    timeprecision 1ps;

    localparam nebula_pkg::wb_adr_t SRAM_BASE = `SRAM_BASE;
    localparam nebula_pkg::wb_adr_t GPIO_BASE = `GPIO_BASE;
    localparam nebula_pkg::wb_adr_t LA_BASE   = `LA_BASE;
    localparam nebula_pkg::wb_adr_t MISS_ADR  = 32'h3005_0000;    // Outside every region

    localparam int          RESET_CYC = 16;
    localparam int          ACK_LIMIT = 20;         // Cycles a manager waits for ack
    localparam int          BUS_CYC   = 6;          // One access plus the idle gap
    localparam int          NUM_ACC   = 21 + 11 + 4 + 5 + 4;
    localparam int          RUN_CYC   = 2 * (RESET_CYC + 2) + BUS_CYC * NUM_ACC + 20;
    localparam int          MARGIN    = 4;
    localparam logic [19:0] PART_SEL  = 20'h5_A_8_6_1;  // Byte selects for overwrites

    logic                                   wb_clk_i = 1'b0;
    logic                                   reset_i;
    logic                                   wbs_cyc_i, wbs_stb_i, wbs_we_i, wbs_ack_o;
    nebula_pkg::wb_sel_t                    wbs_sel_i;
    nebula_pkg::wb_adr_t                    wbs_adr_i;
    nebula_pkg::wb_dat_t                    wbs_dat_i, wbs_dat_o;
    logic                                   team_cyc_i, team_stb_i, team_we_i, team_ack_o;
    nebula_pkg::wb_sel_t                    team_sel_i;
    nebula_pkg::wb_adr_t                    team_adr_i;
    nebula_pkg::wb_dat_t                    team_dat_i, team_dat_o;
    nebula_pkg::pad_vec_t [`NUM_TEAMS-1:0]  team_gpio_out_i;
    nebula_pkg::pad_vec_t [`NUM_TEAMS-1:0]  team_gpio_oeb_i;
    nebula_pkg::la_vec_t  [`NUM_TEAMS-1:0]  team_la_i;
    nebula_pkg::pad_vec_t                   io_out_o, io_oeb_o;
    nebula_pkg::la_vec_t                    la_data_out_o;

    // Reference state kept by the testbench
    logic [31:0]            lfsr = 32'h23f2;
    int                     pass_count = 0;
    int                     fail_count = 0;
    time                    ack_time [2];
    int                     sram_idx [8] = '{0, 1, 7, 31, 64, 128, 200, 255};
    nebula_pkg::wb_dat_t    sram_model [8];
    nebula_pkg::wb_dat_t    gpio_model [5];
    nebula_pkg::wb_dat_t    la_model;
    nebula_pkg::team_sel_t  pin_field [`NUM_PADS];

    nebula_top dut (.*);

    bind nebula_top nebula_assert u_assert (
        .clk_i      (wb_clk_i),
        .reset_i    (reset_i),
        .soc_cyc_i  (wbs_cyc_i),
        .soc_ack_i  (wbs_ack_o),
        .team_cyc_i (team_cyc_i),
        .team_ack_i (team_ack_o),
        .pad_oeb_i  (io_oeb_o)
    );

    always #5 wb_clk_i = ~wb_clk_i;

    // Galois LFSR stepped once per returned bit
    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] r;
        logic         b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ 32'h8020_0003;
            r[i] = b;
        end
        return r;
    endfunction

    function automatic nebula_pkg::la_vec_t la_expect(input nebula_pkg::wb_dat_t word);
        nebula_pkg::la_vec_t e;
        int                  s;
        e = '0;
        for (int k = 0; k < 4; k++) begin
            s = int'(word[8 * k +: 4]);
            if (s >= 1 && s <= `NUM_TEAMS) e[32 * k +: 32] = team_la_i[s - 1][32 * k +: 32];
        end
        return e;
    endfunction

    task automatic check(input string name, input logic [127:0] actual,
                         input logic [127:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0d ns: %s = %0h, expected %0h", $time, name, actual, expected);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%s finished with %0d errors", name, fail_count - errs_before);
    endtask

    task automatic apply_reset();
        @(posedge wb_clk_i);
        reset_i <= 1'b1;
        repeat (RESET_CYC) @(posedge wb_clk_i);
        reset_i <= 1'b0;
    endtask

    // One classic cycle on manager 0 (SoC) or 1 (team)
    task automatic bus_cycle(input int mgr, input logic we, input nebula_pkg::wb_sel_t sel,
                             input nebula_pkg::wb_adr_t adr, input nebula_pkg::wb_dat_t wdat,
                             output nebula_pkg::wb_dat_t rdat);
        int   n;
        logic got;
        n   = 0;
        got = 1'b0;
        @(posedge wb_clk_i);
        if (mgr == 0) begin
            wbs_cyc_i <= 1'b1;
            wbs_stb_i <= 1'b1;
            wbs_we_i  <= we;
            wbs_sel_i <= sel;
            wbs_adr_i <= adr;
            wbs_dat_i <= wdat;
        end else begin
            team_cyc_i <= 1'b1;
            team_stb_i <= 1'b1;
            team_we_i  <= we;
            team_sel_i <= sel;
            team_adr_i <= adr;
            team_dat_i <= wdat;
        end
        while (!got && n < ACK_LIMIT) begin
            @(negedge wb_clk_i);                    // Outputs settled by mid-cycle
            n++;
            got = (mgr == 0) ? wbs_ack_o : team_ack_o;
        end
        rdat          = (mgr == 0) ? wbs_dat_o : team_dat_o;
        ack_time[mgr] = $time;
        if (!got) begin
            $display("Manager %0d got no ack within %0d cycles for address %h",
                     mgr, ACK_LIMIT, adr);
            fail_count++;
        end
        @(posedge wb_clk_i);
        if (mgr == 0) begin
            wbs_cyc_i <= 1'b0;
            wbs_stb_i <= 1'b0;
            wbs_we_i  <= 1'b0;
        end else begin
            team_cyc_i <= 1'b0;
            team_stb_i <= 1'b0;
            team_we_i  <= 1'b0;
        end
    endtask

    task automatic wb_write(input int mgr, input nebula_pkg::wb_adr_t adr,
                            input nebula_pkg::wb_dat_t dat, input nebula_pkg::wb_sel_t sel);
        nebula_pkg::wb_dat_t discard;
        bus_cycle(mgr, 1'b1, sel, adr, dat, discard);
    endtask

    task automatic wb_read(input int mgr, input nebula_pkg::wb_adr_t adr,
                           output nebula_pkg::wb_dat_t dat);
        bus_cycle(mgr, 1'b0, 4'hF, adr, '0, dat);
    endtask

    task automatic test_reset();
        int errs;
        errs = fail_count;
        @(negedge wb_clk_i);
        check("io_oeb_o", 128'(io_oeb_o), 128'({`NUM_PADS{1'b1}}));
        check("io_out_o", 128'(io_out_o), 128'(0));
        check("la_data_out_o", la_data_out_o, '0);
        report_test("test_reset", errs);
    endtask

    task automatic test_sram();
        nebula_pkg::wb_dat_t d;
        nebula_pkg::wb_dat_t rd;
        nebula_pkg::wb_sel_t sel;
        int                  errs;
        errs = fail_count;
        for (int i = 0; i < 8; i++) begin
            d             = 32'(rand_bits(32));
            sram_model[i] = d;
            wb_write(0, SRAM_BASE + 32'(4 * sram_idx[i]), d, 4'hF);
        end
        // Partial overwrites merge into the stored word
        for (int i = 0; i < 5; i++) begin
            d   = 32'(rand_bits(32));
            sel = PART_SEL[4 * i +: 4];
            wb_write(0, SRAM_BASE + 32'(4 * sram_idx[i]), d, sel);
            for (int b = 0; b < 4; b++)
                if (sel[b]) sram_model[i][8 * b +: 8] = d[8 * b +: 8];
        end
        for (int i = 0; i < 8; i++) begin
            wb_read(0, SRAM_BASE + 32'(4 * sram_idx[i]), rd);
            check("wbs_dat_o", 128'(rd), 128'(sram_model[i]));
        end
        report_test("test_sram", errs);
    endtask

    task automatic test_pads();
        nebula_pkg::wb_dat_t  w;
        nebula_pkg::wb_dat_t  rd;
        nebula_pkg::pad_vec_t exp_out;
        nebula_pkg::pad_vec_t exp_oeb;
        int                   p;
        int                   t;
        int                   errs;
        errs = fail_count;
        @(posedge wb_clk_i);
        team_gpio_out_i[0] <= nebula_pkg::pad_vec_t'(rand_bits(`NUM_PADS));
        team_gpio_out_i[1] <= nebula_pkg::pad_vec_t'(rand_bits(`NUM_PADS));
        team_gpio_oeb_i[0] <= nebula_pkg::pad_vec_t'(rand_bits(`NUM_PADS));
        team_gpio_oeb_i[1] <= nebula_pkg::pad_vec_t'(rand_bits(`NUM_PADS));
        for (int i = 0; i < `NUM_PADS; i++)
            pin_field[i] = 4'((i * 3 + 1) % 5);     // 3 and 4 are out of range
        for (int k = 0; k < 5; k++) begin
            w             = '0;
            gpio_model[k] = '0;
            for (int f = 0; f < 8; f++) begin
                p = 8 * k + f;
                if (p < `NUM_PADS) begin
                    w[4 * f +: 4]             = pin_field[p];
                    gpio_model[k][4 * f +: 4] = pin_field[p];
                end else begin
                    w[4 * f +: 4] = 4'hA;           // No pad behind this field
                end
            end
            wb_write(1, GPIO_BASE + 32'(4 * k), w, 4'hF);
        end
        // Byte 1 of word 1 holds pins 10 and 11
        wb_write(0, GPIO_BASE + 32'd4, 32'hFFFF_FFFF, 4'b0010);
        pin_field[10]       = 4'hF;
        pin_field[11]       = 4'hF;
        gpio_model[1][15:8] = 8'hFF;
        for (int k = 0; k < 5; k++) begin
            wb_read(0, GPIO_BASE + 32'(4 * k), rd);
            check($sformatf("wbs_dat_o gpio word %0d", k), 128'(rd), 128'(gpio_model[k]));
        end
        for (int i = 0; i < `NUM_PADS; i++) begin
            t          = int'(pin_field[i]);
            exp_out[i] = 1'b0;
            exp_oeb[i] = 1'b1;
            if (t >= 1 && t <= `NUM_TEAMS) begin
                exp_out[i] = team_gpio_out_i[t - 1][i];
                exp_oeb[i] = team_gpio_oeb_i[t - 1][i];
            end
        end
        @(negedge wb_clk_i);
        check("io_out_o", 128'(io_out_o), 128'(exp_out));
        check("io_oeb_o", 128'(io_oeb_o), 128'(exp_oeb));
        report_test("test_pads", errs);
    endtask

    task automatic test_la();
        nebula_pkg::wb_dat_t rd;
        int                  errs;
        errs = fail_count;
        @(posedge wb_clk_i);
        team_la_i[0] <= nebula_pkg::la_vec_t'(rand_bits(128));
        team_la_i[1] <= nebula_pkg::la_vec_t'(rand_bits(128));
        la_model = 32'h0500_0201;                   // Bank 3 holds an out-of-range index
        wb_write(0, LA_BASE, la_model, 4'hF);
        wb_read(0, LA_BASE, rd);
        check("wbs_dat_o la select", 128'(rd), 128'(la_model));
        @(negedge wb_clk_i);
        check("la_data_out_o", la_data_out_o, la_expect(la_model));
        wb_write(1, LA_BASE, 32'hFFF2_FFFF, 4'b0100);
        la_model = 32'h0502_0201;
        wb_read(1, LA_BASE, rd);
        check("team_dat_o la select", 128'(rd), 128'(la_model));
        @(negedge wb_clk_i);
        check("la_data_out_o", la_data_out_o, la_expect(la_model));
        report_test("test_la", errs);
    endtask

    task automatic test_unmapped();
        nebula_pkg::wb_dat_t rd;
        int                  errs;
        errs = fail_count;
        wb_read(0, MISS_ADR, rd);
        check("wbs_dat_o unmapped", 128'(rd), 128'(0));
        wb_write(0, MISS_ADR, 32'hFFFF_FFFF, 4'hF);
        wb_read(0, SRAM_BASE, rd);                  // Same low address bits as the stray write
        check("wbs_dat_o sram word 0", 128'(rd), 128'(sram_model[0]));
        wb_read(0, GPIO_BASE, rd);
        check("wbs_dat_o gpio word 0", 128'(rd), 128'(gpio_model[0]));
        wb_read(0, LA_BASE, rd);
        check("wbs_dat_o la select", 128'(rd), 128'(la_model));
        report_test("test_unmapped", errs);
    endtask

    task automatic test_arbitration();
        nebula_pkg::wb_dat_t d0;
        nebula_pkg::wb_dat_t d1;
        nebula_pkg::wb_dat_t rd;
        int                  errs;
        errs = fail_count;
        apply_reset();                              // Round-robin record back to manager 1
        d0 = 32'(rand_bits(32));
        d1 = 32'(rand_bits(32));
        fork
            wb_write(0, SRAM_BASE + 32'd80, d0, 4'hF);
            wb_write(1, SRAM_BASE + 32'd84, d1, 4'hF);
        join
        if (ack_time[0] < ack_time[1]) begin
            pass_count++;
        end else begin
            $display("Arbitration order wrong, SoC ack at %0d ns, team ack at %0d ns",
                     ack_time[0], ack_time[1]);
            fail_count++;
        end
        wb_read(0, SRAM_BASE + 32'd84, rd);
        check("wbs_dat_o", 128'(rd), 128'(d1));
        wb_read(1, SRAM_BASE + 32'd80, rd);
        check("team_dat_o", 128'(rd), 128'(d0));
        report_test("test_arbitration", errs);
    endtask

    initial begin
        reset_i         <= 1'b1;
        wbs_cyc_i       <= 1'b0;
        wbs_stb_i       <= 1'b0;
        wbs_we_i        <= 1'b0;
        wbs_sel_i       <= '0;
        wbs_adr_i       <= '0;
        wbs_dat_i       <= '0;
        team_cyc_i      <= 1'b0;
        team_stb_i      <= 1'b0;
        team_we_i       <= 1'b0;
        team_sel_i      <= '0;
        team_adr_i      <= '0;
        team_dat_i      <= '0;
        team_gpio_out_i <= '1;      // Busy team inputs must not leak out of reset
        team_gpio_oeb_i <= '0;
        team_la_i       <= '1;
        apply_reset();
        test_reset();
        test_sram();
        test_pads();
        test_la();
        test_unmapped();
        test_arbitration();
        $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        repeat (RUN_CYC * MARGIN) @(posedge wb_clk_i);
        $display("Watchdog expired after %0d cycles, the tests did not finish", RUN_CYC * MARGIN);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: wb_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-manager Wishbone arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module wb_arbiter (
    input  logic                wb_clk_i,
    input  logic                reset_i,

    // Manager 0, management SoC
    input  logic                s0_cyc_i,
    input  logic                s0_stb_i,
    input  logic                s0_we_i,
    input  nebula_pkg::wb_sel_t s0_sel_i,
    input  nebula_pkg::wb_adr_t s0_adr_i,
    input  nebula_pkg::wb_dat_t s0_dat_i,
    output logic                s0_ack_o,
    output nebula_pkg::wb_dat_t s0_dat_o,

    // Manager 1, team design
    input  logic                s1_cyc_i,
    input  logic                s1_stb_i,
    input  logic                s1_we_i,
    input  nebula_pkg::wb_sel_t s1_sel_i,
    input  nebula_pkg::wb_adr_t s1_adr_i,
    input  nebula_pkg::wb_dat_t s1_dat_i,
    output logic                s1_ack_o,
    output nebula_pkg::wb_dat_t s1_dat_o,

    // Shared bus toward the decoder
    output logic                m_cyc_o,
    output logic                m_stb_o,
    output logic                m_we_o,
    output nebula_pkg::wb_sel_t m_sel_o,
    output nebula_pkg::wb_adr_t m_adr_o,
    output nebula_pkg::wb_dat_t m_dat_o,
    input  logic                m_ack_i,
    input  nebula_pkg::wb_dat_t m_dat_i
);

    nebula_pkg::arb_state_t state, state_nxt;
    logic last_m1;      // Last grant went to manager 1
    logic own0, own1;

    always_comb begin
        state_nxt = state;
        case (state)
            nebula_pkg::ARB_IDLE: begin
                // Tie goes to whoever was not served last
                if (s0_cyc_i && s1_cyc_i) begin
                    state_nxt = last_m1 ? nebula_pkg::ARB_M0 : nebula_pkg::ARB_M1;
                end else if (s0_cyc_i) begin
                    state_nxt = nebula_pkg::ARB_M0;
                end else if (s1_cyc_i) begin
                    state_nxt = nebula_pkg::ARB_M1;
                end
            end
            nebula_pkg::ARB_M0: if (!s0_cyc_i) state_nxt = nebula_pkg::ARB_IDLE;
            nebula_pkg::ARB_M1: if (!s1_cyc_i) state_nxt = nebula_pkg::ARB_IDLE;
            default:            state_nxt = nebula_pkg::ARB_IDLE;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state   <= nebula_pkg::ARB_IDLE;
            last_m1 <= 1'b1;        // Manager 0 wins the first tie
        end else begin
            state <= state_nxt;
            if (state == nebula_pkg::ARB_IDLE && state_nxt != nebula_pkg::ARB_IDLE)
                last_m1 <= (state_nxt == nebula_pkg::ARB_M1);
        end
    end

    assign own0 = (state == nebula_pkg::ARB_M0);
    assign own1 = (state == nebula_pkg::ARB_M1);

    // Handshake lines stay low with no owner
    assign m_cyc_o = (own0 & s0_cyc_i) | (own1 & s1_cyc_i);
    assign m_stb_o = (own0 & s0_stb_i) | (own1 & s1_stb_i);
    assign m_we_o  = own1 ? s1_we_i  : s0_we_i;
    assign m_sel_o = own1 ? s1_sel_i : s0_sel_i;
    assign m_adr_o = own1 ? s1_adr_i : s0_adr_i;
    assign m_dat_o = own1 ? s1_dat_i : s0_dat_i;

    // Response goes back to the owner alone
    assign s0_ack_o = own0 & m_ack_i;
    assign s1_ack_o = own1 & m_ack_i;
    assign s0_dat_o = own0 ? m_dat_i : '0;
    assign s1_dat_o = own1 ? m_dat_i : '0;

endmodule

// File: wb_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone address decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "nebula_params.svh"

module wb_decoder (
    input  logic                wb_clk_i,
    input  logic                reset_i,

    // Shared bus from the arbiter
    input  logic                m_cyc_i,
    input  logic                m_stb_i,
    input  nebula_pkg::wb_adr_t m_adr_i,
    output logic                m_ack_o,
    output nebula_pkg::wb_dat_t m_dat_o,

    // Peripheral strobes
    output logic                sram_stb_o,
    output logic                gpio_stb_o,
    output logic                la_stb_o,

    // Peripheral responses
    input  logic                sram_ack_i,
    input  nebula_pkg::wb_dat_t sram_dat_i,
    input  logic                gpio_ack_i,
    input  nebula_pkg::wb_dat_t gpio_dat_i,
    input  logic                la_ack_i,
    input  nebula_pkg::wb_dat_t la_dat_i
);

    localparam nebula_pkg::wb_adr_t SRAM_BASE = `SRAM_BASE;
    localparam nebula_pkg::wb_adr_t GPIO_BASE = `GPIO_BASE;
    localparam nebula_pkg::wb_adr_t LA_BASE   = `LA_BASE;

    logic req;
    logic hit_sram, hit_gpio, hit_la, miss;
    logic dflt_ack;     // Default responder for unmapped space

    assign req      = m_cyc_i & m_stb_i;
    assign hit_sram = (m_adr_i[31:16] == SRAM_BASE[31:16]);
    assign hit_gpio = (m_adr_i[31:16] == GPIO_BASE[31:16]);
    assign hit_la   = (m_adr_i[31:16] == LA_BASE[31:16]);
    assign miss     = ~(hit_sram | hit_gpio | hit_la);

    assign sram_stb_o = req & hit_sram;
    assign gpio_stb_o = req & hit_gpio;
    assign la_stb_o   = req & hit_la;

    // Keeps the bus from hanging on a stray address
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            dflt_ack <= 1'b0;
        end else begin
            dflt_ack <= req & miss & ~dflt_ack;
        end
    end

    assign m_ack_o = sram_ack_i | gpio_ack_i | la_ack_i | dflt_ack;

    // Only the acking source contributes, default returns zero
    assign m_dat_o = ({32{sram_ack_i}} & sram_dat_i)
                   | ({32{gpio_ack_i}} & gpio_dat_i)
                   | ({32{la_ack_i}}   & la_dat_i);

endmodule

// File: wb_sram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone word SRAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "nebula_params.svh"

module wb_sram (
    input  logic                wb_clk_i,
    input  logic                reset_i,

    input  logic                stb_i,
    input  logic                we_i,
    input  nebula_pkg::wb_sel_t sel_i,
    input  nebula_pkg::wb_adr_t adr_i,
    input  nebula_pkg::wb_dat_t dat_i,
    output logic                ack_o,
    output nebula_pkg::wb_dat_t dat_o
);

    localparam int AW = $clog2(`SRAM_WORDS);

    nebula_pkg::wb_dat_t mem [`SRAM_WORDS];
    logic [AW-1:0]       word_adr;
    logic                access;

    assign word_adr = adr_i[AW+1:2];        // Byte address to word index
    assign access   = stb_i & ~ack_o;       // Skip the cycle after ack

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            if (we_i) begin
                for (int b = 0; b < 4; b++)
                    if (sel_i[b]) mem[word_adr][8 * b +: 8] <= dat_i[8 * b +: 8];
            end
            dat_o <= mem[word_adr];
        end
    end

    // Read data lands together with ack
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

endmodule
